// ==== hw/fpu_wrap_params.svh ====
// FPU wrapper parameters

`ifndef FPU_WRAP_PARAMS_SVH
`define FPU_WRAP_PARAMS_SVH

// ----------------------------------------
// Datapath widths
// ----------------------------------------

// Operand and result width, FP32 only
`define FPU_FLEN 32

// Transaction id carried alongside each request
`define FPU_TAG_W 3

// ----------------------------------------
// FP32 constants
// ----------------------------------------

// Canonical quiet NaN: positive sign, exponent all ones, top mantissa bit
`define FPU_CANON_NAN 32'h7fc0_0000

`endif

// ==== hw/fpu_wrap_pkg.sv ====
// FPU wrapper types

`include "fpu_wrap_params.svh"

package fpu_wrap_pkg;

    // Operator codes as seen by the issue stage
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,  // Sign injection, variant in rm
        FMIN_MAX = 3'd1,  // Min or max, variant in rm
        FCMP     = 3'd2,  // Compare, variant in rm
        FCLASS   = 3'd3,
        FMV_F2X  = 3'd4,  // FPR to GPR move
        FMV_X2F  = 3'd5   // GPR to FPR move
    } fpu_operator_e;

    // Operation groups understood by the core
    typedef enum logic [1:0] {
        OP_SGNJ   = 2'd0,
        OP_MINMAX = 2'd1,
        OP_CMP    = 2'd2,
        OP_CLASS  = 2'd3
    } fpu_core_op_e;

    // Decoded request, travels through hold buffer and first stage
    typedef struct packed {
        logic [`FPU_FLEN-1:0]  a;
        logic [`FPU_FLEN-1:0]  b;
        fpu_core_op_e          op;
        logic [1:0]            mode;      // Variant select, rm[1:0]
        logic                  passthru;  // Return a untouched
        logic [`FPU_TAG_W-1:0] tag;
    } fpu_req_t;

    // Result leaving the core
    typedef struct packed {
        logic [`FPU_FLEN-1:0]  result;
        logic [4:0]            status;  // NV DZ OF UF NX
        logic [`FPU_TAG_W-1:0] tag;
    } fpu_rsp_t;

    // Protocol inversion FSM states
    typedef enum logic {READY, STALL} fpu_hold_state_e;

endpackage

// ==== hw/fpu_op_decode.sv ====
// Issue operator decoder

`timescale 1ns/1ps

`include "fpu_wrap_params.svh"

module fpu_op_decode (
    input  fpu_wrap_pkg::fpu_operator_e operator_i,
    input  logic [`FPU_FLEN-1:0]        operand_a_i,
    input  logic [`FPU_FLEN-1:0]        operand_b_i,
    input  logic [2:0]                  fpu_rm_i,     // Variant select for the op
    input  logic [`FPU_TAG_W-1:0]       trans_id_i,
    output fpu_wrap_pkg::fpu_req_t      req_o
);

    // ----------------------------------------
    // Operator translation
    // ----------------------------------------

    always_comb begin : p_decode
        // Operands and tag pass unchanged
        req_o.a        = operand_a_i;
        req_o.b        = operand_b_i;
        req_o.op       = fpu_wrap_pkg::OP_SGNJ;   // Sign injection by default
        req_o.mode     = fpu_rm_i[1:0];           // MSB of rm masked off
        req_o.passthru = 1'b0;
        req_o.tag      = trans_id_i;

        unique case (operator_i)
            // Sgnj, sgnjn, sgnjx from rm
            fpu_wrap_pkg::FSGNJ: begin
                req_o.op = fpu_wrap_pkg::OP_SGNJ;
            end
            // Min or max from rm
            fpu_wrap_pkg::FMIN_MAX: begin
                req_o.op = fpu_wrap_pkg::OP_MINMAX;
            end
            // Le, lt, eq from rm
            fpu_wrap_pkg::FCMP: begin
                req_o.op = fpu_wrap_pkg::OP_CMP;
            end
            // Class mask with rm ignored by the core
            fpu_wrap_pkg::FCLASS: begin
                req_o.op = fpu_wrap_pkg::OP_CLASS;
            end
            // Both moves map onto sign injection in passthrough mode
            fpu_wrap_pkg::FMV_F2X,
            fpu_wrap_pkg::FMV_X2F: begin
                req_o.op       = fpu_wrap_pkg::OP_SGNJ;
                req_o.passthru = 1'b1;    // Operand a comes back bit for bit
            end
            // Unused codes fall back to the defaults
            default: ;
        endcase
    end

endmodule

// ==== hw/fpu_input_hold.sv ====
// Protocol inversion hold buffer

`timescale 1ns/1ps

module fpu_input_hold (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  fpu_wrap_pkg::fpu_req_t req_i,
    output logic                   core_valid_o,
    input  logic                   core_ready_i,
    output fpu_wrap_pkg::fpu_req_t core_req_o
);

    fpu_wrap_pkg::fpu_hold_state_e state_q, state_d;
    fpu_wrap_pkg::fpu_req_t        hold_q;    // One-entry spill register
    logic                          hold_en;   // Capture live request
    logic                          use_hold;  // Offer held request to core

    // ----------------------------------------
    // READY / STALL FSM
    // ----------------------------------------

    always_comb begin : p_hold_fsm
        req_ready_o  = 1'b0;
        core_valid_o = 1'b0;
        hold_en      = 1'b0;
        use_hold     = 1'b0;
        state_d      = state_q;

        unique case (state_q)
            fpu_wrap_pkg::READY: begin
                req_ready_o  = 1'b1;         // Issue always sees a taker here
                core_valid_o = req_valid_i;  // Live request goes straight on
                // Core busy, park the request and block further issue
                if (req_valid_i && !core_ready_i) begin
                    hold_en = 1'b1;
                    state_d = fpu_wrap_pkg::STALL;
                end
            end
            fpu_wrap_pkg::STALL: begin
                core_valid_o = 1'b1;
                use_hold     = 1'b1;
                if (core_ready_i) begin
                    state_d = fpu_wrap_pkg::READY;  // Held entry consumed
                end
            end
            default: ;
        endcase

        // Flush drops the held entry
        if (flush_i) begin
            state_d = fpu_wrap_pkg::READY;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= fpu_wrap_pkg::READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only, loaded when a request meets a busy core
    always_ff @(posedge clk_i) begin : p_hold_reg
        if (hold_en) begin
            hold_q <= req_i;
        end
    end

    assign core_req_o = use_hold ? hold_q : req_i;  // Held entry has priority

endmodule

// ==== hw/fpu_pipe_reg.sv ====
// Valid/ready pipeline stage

`timescale 1ns/1ps

module fpu_pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the current entry leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;     // Drop whatever is in flight
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin : p_data
        if (valid_i && ready_o) begin
            data_q <= data_i;    // Held under back-pressure
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// ==== hw/fpu_noncomp.sv ====
// FP32 non-computational core

`timescale 1ns/1ps

`include "fpu_wrap_params.svh"

module fpu_noncomp (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    input  logic                   in_valid_i,
    output logic                   in_ready_o,
    input  fpu_wrap_pkg::fpu_req_t req_i,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output fpu_wrap_pkg::fpu_rsp_t rsp_o
);

    fpu_wrap_pkg::fpu_req_t s1_req;
    fpu_wrap_pkg::fpu_rsp_t s1_rsp;       // Result computed from stage 1
    logic                   s1_valid, s1_ready;
    logic [9:0]             cls_a, cls_b; // RISC-V class masks
    logic                   nan_a, nan_b, snan_a, snan_b;
    logic                   lt_raw;       // Ordering with -0 below +0
    logic                   both_zero, feq, flt;
    logic                   nv;

    // RISC-V fclass one-hot mask
    function automatic logic [9:0] fp_class(input logic [`FPU_FLEN-1:0] x);
        logic       sgn;
        logic [7:0] ex;
        logic       man_nz;
        sgn    = x[31];
        ex     = x[30:23];
        man_nz = |x[22:0];
        fp_class = '0;
        if (ex == 8'hff && man_nz)       fp_class[x[22] ? 9 : 8] = 1'b1;  // qNaN / sNaN
        else if (ex == 8'hff)            fp_class[sgn ? 0 : 7]   = 1'b1;  // Infinity
        else if (ex == 8'h00 && man_nz)  fp_class[sgn ? 2 : 5]   = 1'b1;  // Subnormal
        else if (ex == 8'h00)            fp_class[sgn ? 3 : 4]   = 1'b1;  // Zero
        else                             fp_class[sgn ? 1 : 6]   = 1'b1;  // Normal
    endfunction

    // ----------------------------------------
    // Stage 1, request register
    // ----------------------------------------
    fpu_pipe_reg #(.payload_t(fpu_wrap_pkg::fpu_req_t)) i_stage_req (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (in_valid_i), .ready_o (in_ready_o), .data_i (req_i),
        .valid_o (s1_valid),   .ready_i (s1_ready),   .data_o (s1_req)
    );

    // Operand classification
    assign cls_a  = fp_class(s1_req.a);
    assign cls_b  = fp_class(s1_req.b);
    assign nan_a  = cls_a[8] | cls_a[9];
    assign nan_b  = cls_b[8] | cls_b[9];
    assign snan_a = cls_a[8];
    assign snan_b = cls_b[8];

    // Sign-magnitude ordering, negative magnitudes reversed
    assign lt_raw = (s1_req.a[31] != s1_req.b[31]) ? s1_req.a[31] :
                    s1_req.a[31] ? (s1_req.a[30:0] > s1_req.b[30:0]) :
                                   (s1_req.a[30:0] < s1_req.b[30:0]);
    assign both_zero = (s1_req.a[30:0] == '0) && (s1_req.b[30:0] == '0);
    assign feq       = (s1_req.a == s1_req.b) || both_zero;  // +0 equals -0
    assign flt       = lt_raw && !both_zero;

    always_comb begin : p_result
        s1_rsp.result = s1_req.a;
        s1_rsp.tag    = s1_req.tag;
        nv            = 1'b0;
        unique case (s1_req.op)
            fpu_wrap_pkg::OP_SGNJ: begin
                if (!s1_req.passthru) begin
                    unique case (s1_req.mode)
                        2'd0:    s1_rsp.result[31] = s1_req.b[31];
                        2'd1:    s1_rsp.result[31] = !s1_req.b[31];
                        2'd2:    s1_rsp.result[31] = s1_req.a[31] ^ s1_req.b[31];
                        default: ;  // Returns a as is
                    endcase
                end
            end
            fpu_wrap_pkg::OP_MINMAX: begin
                nv = snan_a | snan_b;
                if (nan_a && nan_b)  s1_rsp.result = `FPU_CANON_NAN;
                else if (nan_a)      s1_rsp.result = s1_req.b;     // Other operand wins
                else if (nan_b)      s1_rsp.result = s1_req.a;
                else if (s1_req.mode[0] ^ lt_raw) s1_rsp.result = s1_req.a;  // min: a<b
                else                 s1_rsp.result = s1_req.b;
            end
            fpu_wrap_pkg::OP_CMP: begin
                s1_rsp.result = '0;
                unique case (s1_req.mode)
                    2'd0: begin  // le, signaling on any NaN
                        nv = nan_a | nan_b;
                        s1_rsp.result[0] = !(nan_a | nan_b) && (flt || feq);
                    end
                    2'd1: begin  // lt, signaling on any NaN
                        nv = nan_a | nan_b;
                        s1_rsp.result[0] = !(nan_a | nan_b) && flt;
                    end
                    default: begin  // eq, quiet
                        nv = snan_a | snan_b;
                        s1_rsp.result[0] = !(nan_a | nan_b) && feq;
                    end
                endcase
            end
            fpu_wrap_pkg::OP_CLASS: s1_rsp.result = {22'b0, cls_a};
            default: ;
        endcase
        s1_rsp.status = {nv, 4'b0000};  // Only NV can be raised
    end

    // ----------------------------------------
    // Stage 2, response register
    // ----------------------------------------
    fpu_pipe_reg #(.payload_t(fpu_wrap_pkg::fpu_rsp_t)) i_stage_rsp (
        .clk_i, .rst_ni, .flush_i,
        .valid_i (s1_valid),    .ready_o (s1_ready),    .data_i (s1_rsp),
        .valid_o (out_valid_o), .ready_i (out_ready_i), .data_o (rsp_o)
    );

endmodule

// ==== hw/fpu_wrap.sv ====
// FPU wrapper top level

`timescale 1ns/1ps

`include "fpu_wrap_params.svh"

module fpu_wrap (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        flush_i,
    input  logic                        fpu_valid_i,
    output logic                        fpu_ready_o,
    input  fpu_wrap_pkg::fpu_operator_e operator_i,
    input  logic [`FPU_FLEN-1:0]        operand_a_i,
    input  logic [`FPU_FLEN-1:0]        operand_b_i,
    input  logic [2:0]                  fpu_rm_i,
    input  logic [`FPU_TAG_W-1:0]       trans_id_i,
    output logic                        fpu_valid_o,
    input  logic                        result_ready_i,   // Shared writeback port
    output logic [`FPU_FLEN-1:0]        result_o,
    output logic [4:0]                  fpu_status_o,
    output logic [`FPU_TAG_W-1:0]       fpu_trans_id_o
);

    fpu_wrap_pkg::fpu_req_t dec_req;    // Live decoded request
    fpu_wrap_pkg::fpu_req_t core_req;   // After hold mux
    fpu_wrap_pkg::fpu_rsp_t core_rsp;
    logic                   core_valid, core_ready;

    fpu_op_decode i_decode (
        .operator_i, .operand_a_i, .operand_b_i, .fpu_rm_i, .trans_id_i,
        .req_o (dec_req)
    );

    // Always-accept issue side to valid/ready core side
    fpu_input_hold i_hold (
        .clk_i, .rst_ni, .flush_i,
        .req_valid_i (fpu_valid_i), .req_ready_o (fpu_ready_o), .req_i (dec_req),
        .core_valid_o (core_valid), .core_ready_i (core_ready), .core_req_o (core_req)
    );

    fpu_noncomp i_core (
        .clk_i, .rst_ni, .flush_i,
        .in_valid_i (core_valid),   .in_ready_o (core_ready),      .req_i (core_req),
        .out_valid_o (fpu_valid_o), .out_ready_i (result_ready_i), .rsp_o (core_rsp)
    );

    // Unpack the response
    assign result_o       = core_rsp.result;
    assign fpu_status_o   = core_rsp.status;
    assign fpu_trans_id_o = core_rsp.tag;

endmodule

// ==== test/fpu_wrap_sva.sv ====
// FPU wrapper handshake assertions

`timescale 1ns/1ps

`include "fpu_wrap_params.svh"

module fpu_wrap_sva (
    input logic                          clk_i,
    input logic                          rst_ni,
    input logic                          flush_i,
    input logic                          fpu_ready_o,
    input logic                          fpu_valid_o,
    input logic                          result_ready_i,
    input logic [`FPU_FLEN-1:0]          result_o,
    input logic [4:0]                    fpu_status_o,
    input logic [`FPU_TAG_W-1:0]         fpu_trans_id_o,
    input fpu_wrap_pkg::fpu_hold_state_e hold_state_i   // Hold buffer FSM state
);

    // ----------------------------------------
    // Output side
    // ----------------------------------------

    // Stalled result stays put until taken, flush excepted
    a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fpu_valid_o && !result_ready_i && !flush_i) |=>
        (fpu_valid_o && $stable(result_o) && $stable(fpu_status_o) && $stable(fpu_trans_id_o)))
        else $error("result changed while stalled");

    a_flush_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !fpu_valid_o)                      // Pipeline empty after flush
        else $error("fpu_valid_o high after flush");

    // Issue side blocked only while a request is parked
    a_ready_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !fpu_ready_o |-> (hold_state_i == fpu_wrap_pkg::STALL))
        else $error("fpu_ready_o low outside STALL");

endmodule

bind fpu_wrap fpu_wrap_sva i_sva (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .flush_i        (flush_i),
    .fpu_ready_o    (fpu_ready_o),
    .fpu_valid_o    (fpu_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o),
    .fpu_status_o   (fpu_status_o),
    .fpu_trans_id_o (fpu_trans_id_o),
    .hold_state_i   (i_hold.state_q)
);

// ==== test/tb_fpu_wrap.sv ====
// FPU wrapper testbench

`timescale 1ns/1ps

`include "fpu_wrap_params.svh"

module tb_fpu_wrap;

    localparam int TIMEOUT = 200;  // Cycles allowed per wait loop

    // Expected response of one accepted request
    typedef struct packed {
        logic [`FPU_FLEN-1:0]  result;
        logic [4:0]            status;
        logic [`FPU_TAG_W-1:0] tag;
        logic                  is_class;  // One-hot check on the result
        logic [31:0]           cycle;     // Cycle of acceptance
    } exp_t;

    logic                        clk_i, rst_ni, flush_i;
    logic                        fpu_valid_i, fpu_ready_o;
    fpu_wrap_pkg::fpu_operator_e operator_i;
    logic [`FPU_FLEN-1:0]        operand_a_i, operand_b_i, result_o;
    logic [2:0]                  fpu_rm_i;
    logic [`FPU_TAG_W-1:0]       trans_id_i, fpu_trans_id_o;
    logic                        fpu_valid_o, result_ready_i;
    logic [4:0]                  fpu_status_o;

    integer                seed = 32'h41ab;
    exp_t                  exp_q[$];        // In-order scoreboard
    logic [31:0]           cyc = '0;
    logic [`FPU_TAG_W-1:0] tag_cnt;
    logic                  stall_mode = 1'b0;   // Random writeback stalls
    logic                  lat_check = 1'b0;    // Enforce 2-cycle latency
    logic                  after_flush = 1'b0;
    logic                  next_ready;
    int                    stall_seen = 0;      // Cycles with issue blocked

    fpu_wrap dut (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    // ----------------------------------------
    // Failure reporting
    // ----------------------------------------

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s, got %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    function automatic logic [9:0] class_mask(input logic [31:0] x);
        logic [7:0]  e;
        logic [22:0] f;
        logic        s;
        e = x[30:23];
        f = x[22:0];
        s = x[31];
        if (e == 8'hff) begin
            if (f == 23'd0) return s ? 10'h001 : 10'h080;  // Infinities
            return f[22] ? 10'h200 : 10'h100;             // Quiet or signaling NaN
        end
        if (e == 8'h00) begin
            if (f == 23'd0) return s ? 10'h008 : 10'h010;  // Zeros
            return s ? 10'h004 : 10'h020;                 // Subnormals
        end
        return s ? 10'h002 : 10'h040;
    endfunction

    function automatic logic [36:0] ref_fpu(input fpu_wrap_pkg::fpu_operator_e op,
                                            input logic [2:0] rm,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] res, ka, kb;
        logic        na, nb, sa, sb, zz, lt, eq, nv;
        na = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
        nb = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
        sa = na && !a[22];
        sb = nb && !b[22];
        ka = a[31] ? ~a : {1'b1, a[30:0]};  // Monotonic key where -0 sorts below +0
        kb = b[31] ? ~b : {1'b1, b[30:0]};
        zz = (a[30:0] == 31'd0) && (b[30:0] == 31'd0);
        lt = (ka < kb) && !zz;
        eq = (a == b) || zz;
        res = a;
        nv  = 1'b0;
        case (op)
            fpu_wrap_pkg::FSGNJ: begin
                if (rm[1:0] == 2'd0) res[31] = b[31];
                else if (rm[1:0] == 2'd1) res[31] = ~b[31];
                else if (rm[1:0] == 2'd2) res[31] = a[31] ^ b[31];
            end
            fpu_wrap_pkg::FMIN_MAX: begin
                nv = sa || sb;
                if (na && nb) res = `FPU_CANON_NAN;
                else if (na) res = b;
                else if (nb) res = a;
                else if (rm[0]) res = (ka > kb) ? a : b;  // Max
                else res = (ka < kb) ? a : b;
            end
            fpu_wrap_pkg::FCMP: begin
                nv = (rm[1:0] == 2'd2) ? (sa || sb) : (na || nb);  // Eq is quiet
                if (rm[1:0] == 2'd0) res = {31'd0, !(na || nb) && (lt || eq)};
                else if (rm[1:0] == 2'd1) res = {31'd0, !(na || nb) && lt};
                else res = {31'd0, !(na || nb) && eq};
            end
            fpu_wrap_pkg::FCLASS: res = {22'd0, class_mask(a)};
            default: res = a;  // Moves return a bit for bit
        endcase
        return {res, nv, 4'b0000};
    endfunction

    // ----------------------------------------
    // Scoreboard sampled mid-cycle
    // ----------------------------------------

    always @(negedge clk_i) begin : monitor
        exp_t item;
        if (rst_ni) begin
            if (after_flush) check_value({31'd0, fpu_valid_o}, 32'd0, "fpu_valid_o after flush");
            after_flush = flush_i;
            if (fpu_valid_i && !fpu_ready_o) stall_seen++;
            if (fpu_valid_o && result_ready_i) begin
                if (exp_q.size() == 0) begin
                    stop_with_failure("A result came out with no request pending");
                end else begin
                    item = exp_q.pop_front();
                    check_value(result_o, item.result, "result");
                    check_value({27'd0, fpu_status_o}, {27'd0, item.status}, "status");
                    check_value({29'd0, fpu_trans_id_o}, {29'd0, item.tag}, "tag");
                    if (item.is_class) check_value($countones(result_o), 1, "class bits set");
                    if (lat_check) check_value(cyc - item.cycle, 32'd2, "latency");
                end
            end
            if (flush_i) begin
                exp_q.delete();                    // Everything in flight is dropped
            end else if (fpu_valid_i && fpu_ready_o) begin
                {item.result, item.status} = ref_fpu(operator_i, fpu_rm_i,
                                                     operand_a_i, operand_b_i);
                item.tag      = trans_id_i;
                item.is_class = (operator_i == fpu_wrap_pkg::FCLASS);
                item.cycle    = cyc;
                exp_q.push_back(item);
            end
        end
    end

    // Writeback back-pressure drawn mid-cycle and applied after the edge
    initial begin : ready_driver
        logic [31:0] r;
        forever begin
            @(negedge clk_i);
            r = $random(seed);
            next_ready = !stall_mode || (r[1:0] != 2'b00);
            @(posedge clk_i);
            #1;
            result_ready_i = next_ready;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    function automatic logic [31:0] special_value(input logic [3:0] idx);
        case (idx)
            4'd0:    return 32'h0000_0000;  // +0
            4'd1:    return 32'h8000_0000;  // -0
            4'd2:    return 32'h7f80_0000;  // +inf
            4'd3:    return 32'hff80_0000;  // -inf
            4'd4:    return 32'h7fc0_0000;  // qNaN
            4'd5:    return 32'hffc1_2345;
            4'd6:    return 32'h7f80_0001;  // sNaN
            4'd7:    return 32'hffa0_0000;
            4'd8:    return 32'h0000_0001;  // Denormals
            4'd9:    return 32'h807f_ffff;
            4'd10:   return 32'h3f80_0000;  // +1.0
            default: return 32'hbf80_0000;  // -1.0
        endcase
    endfunction

    function automatic logic [31:0] random_operand();
        logic [31:0] sel;
        sel = $random(seed);
        if (sel[3:0] < 4'd12) return special_value(sel[3:0]);
        return $random(seed);
    endfunction

    // Present one request and hold it until the wrapper accepts
    task automatic send(input fpu_wrap_pkg::fpu_operator_e op, input logic [2:0] rm,
                        input logic [31:0] a, input logic [31:0] b);
        int waited;
        fpu_valid_i = 1'b1;
        operator_i  = op;
        fpu_rm_i    = rm;
        operand_a_i = a;
        operand_b_i = b;
        trans_id_i  = tag_cnt;
        waited      = 0;
        @(negedge clk_i);
        while (!fpu_ready_o) begin
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout, a request was never accepted");
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        fpu_valid_i = 1'b0;
        tag_cnt     = tag_cnt + 1'b1;
    endtask

    task automatic send_random();
        logic [31:0]                 r;
        fpu_wrap_pkg::fpu_operator_e op;
        logic [2:0]                  rm;
        r  = $random(seed);
        op = fpu_wrap_pkg::fpu_operator_e'(r[2:0] % 3'd6);
        rm = r[6:4];
        if (op == fpu_wrap_pkg::FMIN_MAX) rm[1] = 1'b0;    // Min or max only
        else if (rm[1:0] == 2'b11) rm[1:0] = 2'b10;        // No variant at 3
        send(op, rm, random_operand(), random_operand());
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            waited++;
            if (waited > TIMEOUT) stop_with_failure("Timeout, results still pending");
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic flush_pulse();
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
    endtask

    initial begin : stimulus
        int          i, j, m;
        logic [31:0] va, vb;
        rst_ni         = 1'b0;
        flush_i        = 1'b0;
        fpu_valid_i    = 1'b0;
        operator_i     = fpu_wrap_pkg::FSGNJ;
        operand_a_i    = '0;
        operand_b_i    = '0;
        fpu_rm_i       = '0;
        trans_id_i     = '0;
        result_ready_i = 1'b1;
        tag_cnt        = '0;
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        // Idle outputs then one request with fixed latency
        @(negedge clk_i);
        check_value({31'd0, fpu_valid_o}, 32'd0, "fpu_valid_o after reset");
        check_value({31'd0, fpu_ready_o}, 32'd1, "fpu_ready_o after reset");
        @(posedge clk_i);
        #1;
        lat_check = 1'b1;
        send(fpu_wrap_pkg::FSGNJ, 3'd1, 32'h3f80_0000, 32'h0000_0000);
        drain();
        lat_check = 1'b0;

        // All special pairs through sign injection, min/max and compare
        for (i = 0; i < 12; i++) begin
            va = special_value(i[3:0]);
            for (j = 0; j < 12; j++) begin
                vb = special_value(j[3:0]);
                for (m = 0; m < 3; m++) begin
                    send(fpu_wrap_pkg::FSGNJ, m[2:0], va, vb);
                    send(fpu_wrap_pkg::FCMP, m[2:0], va, vb);
                end
                send(fpu_wrap_pkg::FMIN_MAX, 3'd0, va, vb);
                send(fpu_wrap_pkg::FMIN_MAX, 3'd5, va, vb);
            end
            send(fpu_wrap_pkg::FCLASS, 3'd0, va, 32'd0);
        end
        for (m = 0; m < 8; m++) begin             // Moves under every rm value
            for (i = 0; i < 12; i++) begin
                send(fpu_wrap_pkg::FMV_F2X, m[2:0], special_value(i[3:0]), random_operand());
                send(fpu_wrap_pkg::FMV_X2F, m[2:0], random_operand(), special_value(i[3:0]));
            end
        end
        drain();

        // Random back-to-back stream under writeback stalls
        stall_mode = 1'b1;
        repeat (300) send_random();
        drain();
        check_value({31'd0, stall_seen != 0}, 32'd1, "fpu_ready_o dropped under stalls");

        // Flush in the middle of a stream
        repeat (15) send_random();
        flush_pulse();
        repeat (15) send_random();
        drain();
        stall_mode = 1'b0;

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== fpu_wrap.f ====
+incdir+hw
hw/fpu_wrap_pkg.sv
hw/fpu_op_decode.sv
hw/fpu_input_hold.sv
hw/fpu_pipe_reg.sv
hw/fpu_noncomp.sv
hw/fpu_wrap.sv
test/fpu_wrap_sva.sv
test/tb_fpu_wrap.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fpu_wrap
FILELIST = fpu_wrap.f
BUILD    = obj_dir
PASS_MSG = All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)
